// ==== compile.f ====
verilog/core_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/decoder.sv
verilog/apb_mem_port.sv
verilog/core_control.sv
verilog/riscv_core.sv
sim/tb_apb_memory.sv
sim/tb_riscv_core.sv

// ==== sim/core_golden.txt ====
// word 0 program word count, word 1 expected store count
// then program words from address 0, then stores as paddr pwdata pstrb
00000043
0000001b
000010b7 // 00 lui   x1, 0x1
12345137 // 04 lui   x2, 0x12345
67810113 // 08 addi  x2, x2, 0x678
0020a023 // 0c sw    x2, 0(x1)
00002197 // 10 auipc x3, 0x2
0030a223 // 14 sw    x3, 4(x1)
ffb00213 // 18 addi  x4, x0, -5
ffc22293 // 1c slti  x5, x4, -4
00723313 // 20 sltiu x6, x4, 7
0050a423 // 24 sw    x5, 8(x1)
0060a623 // 28 sw    x6, 12(x1)
0ff14393 // 2c xori  x7, x2, 0xff
7003e413 // 30 ori   x8, x7, 0x700
f0047493 // 34 andi  x9, x8, -256
0080a823 // 38 sw    x8, 16(x1)
0090aa23 // 3c sw    x9, 20(x1)
00421513 // 40 slli  x10, x4, 4
01c25593 // 44 srli  x11, x4, 28
40125613 // 48 srai  x12, x4, 1
00a0ac23 // 4c sw    x10, 24(x1)
00b0ae23 // 50 sw    x11, 28(x1)
02c0a023 // 54 sw    x12, 32(x1)
004106b3 // 58 add   x13, x2, x4
40410733 // 5c sub   x14, x2, x4
00b227b3 // 60 slt   x15, x4, x11
0045b833 // 64 sltu  x16, x11, x4
00b798b3 // 68 sll   x17, x15, x11
010888b3 // 6c add   x17, x17, x16
00414933 // 70 xor   x18, x2, x4
0025e9b3 // 74 or    x19, x11, x2
01397a33 // 78 and   x20, x18, x19
00b25ab3 // 7c srl   x21, x4, x11
40b25b33 // 80 sra   x22, x4, x11
02d0a223 // 84 sw    x13, 36(x1)
02e0a423 // 88 sw    x14, 40(x1)
0310a623 // 8c sw    x17, 44(x1)
0320a823 // 90 sw    x18, 48(x1)
0330aa23 // 94 sw    x19, 52(x1)
0340ac23 // 98 sw    x20, 56(x1)
0350ae23 // 9c sw    x21, 60(x1)
0560a023 // a0 sw    x22, 64(x1)
07b00013 // a4 addi  x0, x0, 123
0400a223 // a8 sw    x0, 68(x1)
044084a3 // ac sb    x4, 73(x1)
05209723 // b0 sh    x18, 78(x1)
04908c03 // b4 lb    x24, 73(x1)
04e09c83 // b8 lh    x25, 78(x1)
0000ad03 // bc lw    x26, 0(x1)
0580a823 // c0 sw    x24, 80(x1)
0590aa23 // c4 sw    x25, 84(x1)
05a0ac23 // c8 sw    x26, 88(x1)
01078463 // cc beq   x15, x16, +8   taken
04b0ae23 // d0 sw    x11, 92(x1)    skipped
01079463 // d4 bne   x15, x16, +8   not taken
04f0ae23 // d8 sw    x15, 92(x1)
00b78463 // dc beq   x15, x11, +8   not taken
06b0a023 // e0 sw    x11, 96(x1)
00b79463 // e4 bne   x15, x11, +8   taken
0620a223 // e8 sw    x2, 100(x1)    skipped
00800def // ec jal   x27, +8
0620a223 // f0 sw    x2, 100(x1)    skipped
07b0a223 // f4 sw    x27, 100(x1)
00000e17 // f8 auipc x28, 0
00de0ee7 // fc jalr  x29, 13(x28)   lands on 104
0620a423 // 100 sw   x2, 104(x1)    skipped
07d0a423 // 104 sw   x29, 104(x1)
0000006f // 108 jal  x0, 0
// expected stores in order
00001000 12345678 f
00001004 00002010 f
00001008 00000001 f
0000100c 00000000 f
00001010 12345787 f
00001014 12345700 f
00001018 ffffffb0 f
0000101c 0000000f f
00001020 fffffffd f
00001024 12345673 f
00001028 1234567d f
0000102c 00008001 f
00001030 edcba983 f
00001034 1234567f f
00001038 00000003 f
0000103c 0001ffff f
00001040 ffffffff f
00001044 00000000 f
00001048 fffffb00 2
0000104c a9830000 c
00001050 fffffffb f
00001054 ffffa983 f
00001058 12345678 f
0000105c 00000001 f
00001060 0000000f f
00001064 000000f0 f
00001068 00000100 f

// ==== sim/tb_apb_memory.sv ====
/*
 * APB slave memory model
 * word memory with zero to three random wait states per transfer,
 * reports every completed write with its address, data and strobes
 */
module tb_apb_memory #(
    parameter int          ADDR_WIDTH = 20,
    parameter int          DEPTH      = 2048,
    parameter logic [31:0] SEED       = 32'h1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ADDR_WIDTH-1:0]     paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [core_pkg::XLEN-1:0] pwdata,
    input  logic [3:0]                pstrb,
    output logic [core_pkg::XLEN-1:0] prdata,
    output logic                      pready,
    output logic                      wr_valid,
    output logic [ADDR_WIDTH-1:0]     wr_addr,
    output logic [core_pkg::XLEN-1:0] wr_data,
    output logic [3:0]                wr_strb
);
    timeunit 1ns;
    timeprecision 1ns;
    import core_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [XLEN-1:0]  mem [0:DEPTH-1];
    logic [IDX_W-1:0] index;
    logic [1:0]       wait_cnt;
    logic [XLEN-1:0]  rnd;
    logic [XLEN-1:0]  merged;
    integer           seed;

    assign index = paddr[IDX_W+1:2];

    initial begin
        seed     = SEED;
        prdata   = '0;
        pready   = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_strb  = '0;
        wait_cnt = '0;
    end

    // fill value built from the byte address
    task automatic fill_pattern();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'ha500_0000 | (i << 2);
        end
    endtask

    task automatic write_word(input int word_index, input logic [XLEN-1:0] data);
        mem[word_index] = data;
    endtask

    // --------------------------------------------------
    // setup picks the wait count, access counts it down
    // --------------------------------------------------
    always @(posedge clk) begin
        wr_valid <= 1'b0;
        if (!rst) begin
            pready   <= 1'b0;
            wait_cnt <= '0;
        end else if (psel && !penable) begin
            rnd = $random(seed);
            wait_cnt <= rnd[1:0];
            pready   <= (rnd[1:0] == 2'd0);
            prdata   <= mem[index];
        end else if (psel && penable && !pready) begin
            wait_cnt <= wait_cnt - 2'd1;
            pready   <= (wait_cnt == 2'd1);
        end else if (psel && penable && pready) begin
            pready <= 1'b0;
            if (pwrite) begin
                merged = mem[index];
                for (int b = 0; b < 4; b++) begin
                    if (pstrb[b]) begin
                        merged[8*b +: 8] = pwdata[8*b +: 8];
                    end
                end
                mem[index] <= merged;
                wr_valid   <= 1'b1;
                wr_addr    <= paddr;
                wr_data    <= pwdata;
                wr_strb    <= pstrb;
            end
        end
    end

endmodule

// ==== sim/tb_riscv_core.sv ====
/*
 * testbench for the rv32i core
 * loads the program from the golden file, runs it against an APB memory
 * with random wait states, checks the APB handshake and every store in order
 */
module tb_riscv_core;
    timeunit 1ns;
    timeprecision 1ns;
    import core_pkg::*;

    localparam int          ADDR_WIDTH     = 20;
    localparam int          CLK_PERIOD     = 20;
    localparam int          GOLDEN_DEPTH   = 256;
    localparam int          TIMEOUT_FACTOR = 16 * 2;
    localparam int          DRAIN_CYCLES   = 64;
    localparam logic [31:0] SEED           = 32'he903;
    localparam string       GOLDEN_FILE    = "sim/core_golden.txt";

    logic                  clk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel, penable, pwrite;
    logic [XLEN-1:0]       pwdata, prdata;
    logic [3:0]            pstrb;
    logic                  pready;
    logic                  wr_valid;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    logic [3:0]            wr_strb;

    // bus values of the cycle before
    logic                  prev_psel, prev_penable, prev_pready, prev_pwrite;
    logic [ADDR_WIDTH-1:0] prev_paddr;
    logic [XLEN-1:0]       prev_pwdata;
    logic [3:0]            prev_pstrb;

    logic [XLEN-1:0] golden [0:GOLDEN_DEPTH-1];
    int              n_prog, n_stores, store_idx, cycles, timeout_limit, drain, base;

    riscv_core #(.ADDR_WIDTH(ADDR_WIDTH), .RESET_PC(32'h0)) UUT (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

    tb_apb_memory #(.ADDR_WIDTH(ADDR_WIDTH), .SEED(SEED)) u_memory (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_store(
        input string                 name,
        input logic [ADDR_WIDTH-1:0] exp_addr,
        input logic [XLEN-1:0]       exp_data,
        input logic [3:0]            exp_strb,
        input logic [ADDR_WIDTH-1:0] act_addr,
        input logic [XLEN-1:0]       act_data,
        input logic [3:0]            act_strb
    );
        if (act_addr !== exp_addr) begin
            $display("Error: %s paddr expected %h actual %h", name, exp_addr, act_addr);
            stop_run();
        end else if (act_data !== exp_data) begin
            $display("Error: %s pwdata expected %h actual %h", name, exp_data, act_data);
            stop_run();
        end else if (act_strb !== exp_strb) begin
            $display("Error: %s pstrb expected %b actual %b", name, exp_strb, act_strb);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Error: %s expected %b actual %b", name, exp_val, act_val);
            stop_run();
        end
    endtask

    task automatic check_strobe(
        input string      name,
        input logic [3:0] exp_strb,
        input logic [3:0] act_strb
    );
        if (act_strb !== exp_strb) begin
            $display("Error: %s expected %b actual %b", name, exp_strb, act_strb);
            stop_run();
        end
    endtask

    // one setup cycle, access held until pready, request fields stable
    task automatic check_bus_protocol();
        if (cycles == 1) begin
            check_bit("psel after reset", 1'b0, psel);
            check_bit("penable after reset", 1'b0, penable);
        end
        if (cycles == 2) begin
            check_bit("psel of first setup", 1'b1, psel);
            check_bit("penable of first setup", 1'b0, penable);
        end
        if (penable) begin
            check_bit("psel during access", 1'b1, psel);
        end
        if (psel && !prev_psel) begin
            check_bit("penable in setup", 1'b0, penable);
        end
        if (prev_psel && !(prev_penable && prev_pready)) begin
            check_bit("psel held into access", 1'b1, psel);
            check_bit("penable after setup or wait", 1'b1, penable);
            check_bit("pwrite held in access", prev_pwrite, pwrite);
            check_store("bus held in access", prev_paddr, prev_pwdata, prev_pstrb,
                        paddr, pwdata, pstrb);
        end
        if (psel && !pwrite) begin
            check_strobe("pstrb on read", 4'b0000, pstrb);
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_pready  = pready;
        prev_pwrite  = pwrite;
        prev_paddr   = paddr;
        prev_pwdata  = pwdata;
        prev_pstrb   = pstrb;
    endtask

    // --------------------------------------------------
    // load, reset, then watch the write reports
    // --------------------------------------------------
    initial begin
        rst = 1'b0;
        $readmemh(GOLDEN_FILE, golden);
        n_prog        = golden[0];
        n_stores      = golden[1];
        timeout_limit = n_prog * TIMEOUT_FACTOR;
        if (n_prog <= 0 || n_stores <= 0) begin
            $display("golden file %s is missing or holds no program", GOLDEN_FILE);
            stop_run();
        end else begin
            u_memory.fill_pattern();
            for (int i = 0; i < n_prog; i++) begin
                u_memory.write_word(i, golden[2 + i]);
            end
        end

        repeat (4) @(posedge clk);
        rst <= 1'b1;

        store_idx    = 0;
        cycles       = 0;
        drain        = 0;
        prev_psel    = 1'b0;
        prev_penable = 1'b0;
        prev_pready  = 1'b0;
        // keep watching a while after the last store to catch extra ones
        while (drain < DRAIN_CYCLES) begin
            @(posedge clk);
            cycles++;
            check_bus_protocol();
            if (wr_valid) begin
                base = 2 + n_prog + 3 * store_idx;
                if (store_idx >= n_stores) begin
                    $display("unexpected store to %h after the last expected store", wr_addr);
                    stop_run();
                end else begin
                    check_store($sformatf("store %0d", store_idx),
                                golden[base][ADDR_WIDTH-1:0], golden[base + 1],
                                golden[base + 2][3:0], wr_addr, wr_data, wr_strb);
                    store_idx++;
                end
            end
            if (store_idx == n_stores) begin
                drain++;
            end
            if (cycles >= timeout_limit) begin
                $display("timeout after %0d cycles, %0d of %0d stores seen",
                         cycles, store_idx, n_stores);
                stop_run();
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
/*
 * alu
 * add, sub, compares, logic and shifts, plus an equality flag for branches
 */
module alu (
    input  core_pkg::alu_op_e         op,
    input  logic [core_pkg::XLEN-1:0] a,
    input  logic [core_pkg::XLEN-1:0] b,
    output logic [core_pkg::XLEN-1:0] result,
    output logic                      eq
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];
    assign eq    = (a == b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            default:  result = b;
        endcase
    end

endmodule

// ==== verilog/apb_mem_port.sv ====
/*
 * APB4 master port
 * runs one transfer per request, places store bytes in their lanes and
 * returns load data shifted down and sign-extended
 */
module apb_mem_port #(
    parameter int ADDR_WIDTH = 20
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_req,
    input  logic                      mem_write,
    input  logic [ADDR_WIDTH-1:0]     mem_addr,
    input  logic [core_pkg::XLEN-1:0] mem_wdata,
    input  core_pkg::mem_size_e       mem_size,
    output logic                      mem_done,
    output logic [core_pkg::XLEN-1:0] mem_rdata,
    output logic [ADDR_WIDTH-1:0]     paddr,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [core_pkg::XLEN-1:0] pwdata,
    output logic [3:0]                pstrb,
    input  logic [core_pkg::XLEN-1:0] prdata,
    input  logic                      pready
);
    import core_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    logic [1:0]      state;
    mem_size_e       size_q;
    logic [1:0]      offset_q;
    logic [3:0]      strb_mask;
    logic [XLEN-1:0] rdata_shift, load_data;

    assign psel    = (state != ST_IDLE);
    assign penable = (state == ST_ACCESS);

    always_comb begin
        case (mem_size)
            MEM_BYTE: strb_mask = 4'b0001;
            MEM_HALF: strb_mask = 4'b0011;
            default:  strb_mask = 4'b1111;
        endcase
    end

    // ------------------------------------------------
    // load extraction
    // ------------------------------------------------
    assign rdata_shift = prdata >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            MEM_BYTE: load_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            MEM_HALF: load_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            default:  load_data = prdata;
        endcase
    end

    // idle, setup for one cycle, access until pready
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= ST_IDLE;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                ST_IDLE: if (mem_req) state <= ST_SETUP;
                ST_SETUP: state <= ST_ACCESS;
                default: begin
                    if (pready) begin
                        state    <= ST_IDLE;
                        mem_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // request capture, held stable through both phases
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && mem_req) begin
            paddr    <= {mem_addr[ADDR_WIDTH-1:2], 2'b00};
            pwrite   <= mem_write;
            pwdata   <= mem_wdata << {mem_addr[1:0], 3'b000};
            pstrb    <= mem_write ? strb_mask << mem_addr[1:0] : 4'b0000;
            size_q   <= mem_size;
            offset_q <= mem_addr[1:0];
        end
        if (state == ST_ACCESS && pready) begin
            mem_rdata <= load_data;
        end
    end

endmodule

// ==== verilog/core_control.sv ====
/*
 * step sequencer of the core
 * holds pc, fetched instruction and stage results, issues bus transfers
 * and picks the next pc in write-back
 */
module core_control #(
    parameter int                        ADDR_WIDTH = 20,
    parameter logic [core_pkg::XLEN-1:0] RESET_PC   = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    output core_pkg::instr_u          instr,
    input  core_pkg::branch_e         branch,
    input  core_pkg::wb_sel_e         wb_sel,
    input  logic                      mem_read,
    input  logic                      mem_write_op,
    input  core_pkg::mem_size_e       mem_size_op,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic [core_pkg::XLEN-1:0] alu_result,
    input  logic                      alu_eq,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      rd_we,
    output logic [core_pkg::XLEN-1:0] rd_data,
    output logic                      mem_req,
    output logic                      mem_write,
    output logic [ADDR_WIDTH-1:0]     mem_addr,
    output logic [core_pkg::XLEN-1:0] mem_wdata,
    output core_pkg::mem_size_e       mem_size,
    input  logic                      mem_done,
    input  logic [core_pkg::XLEN-1:0] mem_rdata
);
    import core_pkg::*;

    localparam logic [2:0] S_BOOT     = 3'd0;
    localparam logic [2:0] S_IF       = 3'd1;
    localparam logic [2:0] S_ID       = 3'd2;
    localparam logic [2:0] S_EX       = 3'd3;
    localparam logic [2:0] S_MEM      = 3'd4;
    localparam logic [2:0] S_MEM_WAIT = 3'd5;
    localparam logic [2:0] S_WB       = 3'd6;

    logic [2:0]      state;
    logic [XLEN-1:0] alu_q, load_q;
    logic            eq_q;
    logic            taken;
    logic [XLEN-1:0] pc_plus4, next_pc, fetch_addr;

    // ------------------------------------------------
    // branch decision and next pc
    // ------------------------------------------------
    always_comb begin
        case (branch)
            BR_BEQ:  taken = eq_q;
            BR_BNE:  taken = !eq_q;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4   = pc + 4;
    assign next_pc    = (branch == BR_JALR) ? {alu_q[XLEN-1:1], 1'b0} :
                        taken ? pc + imm : pc_plus4;
    // write-back already requests the next fetch
    assign fetch_addr = (state == S_WB) ? next_pc : pc;

    always_comb begin
        case (wb_sel)
            WB_LOAD: rd_data = load_q;
            WB_PC4:  rd_data = pc_plus4;
            default: rd_data = alu_q;
        endcase
    end

    assign rd_we = (state == S_WB) && (wb_sel != WB_NONE);

    // bus request, data access only in the memory step
    assign mem_req   = (state == S_BOOT) || (state == S_MEM) || (state == S_WB);
    assign mem_write = (state == S_MEM) && mem_write_op;
    assign mem_size  = (state == S_MEM) ? mem_size_op : MEM_WORD;
    assign mem_addr  = (state == S_MEM) ? alu_q[ADDR_WIDTH-1:0] : fetch_addr[ADDR_WIDTH-1:0];
    assign mem_wdata = rs2_data;

    // ------------------------------------------------
    // sequencer
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_BOOT;
            pc    <= RESET_PC;
        end else begin
            case (state)
                S_BOOT: state <= S_IF;
                S_IF: if (mem_done) state <= S_ID;
                S_ID: state <= S_EX;
                S_EX: state <= (mem_read || mem_write_op) ? S_MEM : S_WB;
                S_MEM: state <= S_MEM_WAIT;
                S_MEM_WAIT: if (mem_done) state <= S_WB;
                default: begin
                    pc    <= next_pc;
                    state <= S_IF;
                end
            endcase
        end
    end

    // stage results
    always_ff @(posedge clk) begin
        if (state == S_IF && mem_done) begin
            instr <= mem_rdata;
        end
        if (state == S_EX) begin
            alu_q <= alu_result;
            eq_q  <= alu_eq;
        end
        if (state == S_MEM_WAIT && mem_done) begin
            load_q <= mem_rdata;
        end
    end

endmodule

// ==== verilog/core_pkg.sv ====
/*
 * core package
 * widths, opcodes and control encodings of the rv32i core, and the
 * instruction word with one view per encoding format
 */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {SRC_RS1, SRC_PC, SRC_ZERO} src_a_e;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL, BR_JALR} branch_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    // ------------------------------------------------
    // one instruction word, six field layouts
    // ------------------------------------------------
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// ==== verilog/decoder.sv ====
/*
 * instruction decoder
 * classifies the opcode, builds the immediate and the control fields,
 * unsupported encodings come out as a no-op
 */
module decoder (
    input  core_pkg::instr_u                instr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [core_pkg::REG_ADDR_W-1:0] rd,
    output core_pkg::alu_op_e               alu_op,
    output core_pkg::src_a_e                src_a,
    output logic                            use_imm,
    output core_pkg::branch_e               branch,
    output core_pkg::wb_sel_e               wb_sel,
    output logic                            mem_read,
    output logic                            mem_write_op,
    output core_pkg::mem_size_e             mem_size_op,
    output logic [core_pkg::XLEN-1:0]       imm
);
    import core_pkg::*;

    logic [XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [2:0]      funct3;
    logic            alt;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  arith_op = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;
    assign funct3 = instr.r.funct3;
    // bit 30 picks sub and sra
    assign alt    = instr.r.funct7[5];

    // immediates, sign taken from bit 31
    assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign b_imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
    assign u_imm = {instr.u.imm, 12'b0};
    assign j_imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

    always_comb begin
        alu_op       = ALU_PASS_B;
        src_a        = SRC_RS1;
        use_imm      = 1'b1;
        branch       = BR_NONE;
        wb_sel       = WB_NONE;
        mem_read     = 1'b0;
        mem_write_op = 1'b0;
        mem_size_op  = MEM_WORD;
        imm          = i_imm;
        case (instr.r.opcode)
            OP_LUI, OP_AUIPC: begin
                src_a  = (instr.r.opcode == OP_LUI) ? SRC_ZERO : SRC_PC;
                alu_op = ALU_ADD;
                imm    = u_imm;
                wb_sel = WB_ALU;
            end
            OP_JAL: begin
                imm    = j_imm;
                branch = BR_JAL;
                wb_sel = WB_PC4;
            end
            OP_JALR: begin
                alu_op = ALU_ADD;
                branch = BR_JALR;
                wb_sel = WB_PC4;
            end
            OP_BRANCH: begin
                use_imm = 1'b0;
                imm     = b_imm;
                if (funct3 == 3'b000) begin
                    branch = BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    branch = BR_BNE;
                end
            end
            // signed sizes only
            OP_LOAD, OP_STORE: begin
                if (funct3 <= 3'b010) begin
                    alu_op      = ALU_ADD;
                    mem_size_op = mem_size_e'(funct3[1:0]);
                    if (instr.r.opcode == OP_LOAD) begin
                        mem_read = 1'b1;
                        wb_sel   = WB_LOAD;
                    end else begin
                        mem_write_op = 1'b1;
                        imm          = s_imm;
                    end
                end
            end
            OP_IMM: begin
                alu_op = arith_op(funct3, alt && funct3 == 3'b101);
                wb_sel = WB_ALU;
            end
            OP_REG: begin
                use_imm = 1'b0;
                alu_op  = arith_op(funct3, alt);
                wb_sel  = WB_ALU;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
/*
 * register file
 * x1 to x31 with two asynchronous read ports, x0 is hardwired zero
 */
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd,
    input  logic                            we,
    input  logic [core_pkg::XLEN-1:0]       wdata,
    output logic [core_pkg::XLEN-1:0]       rs1_data,
    output logic [core_pkg::XLEN-1:0]       rs2_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/riscv_core.sv ====
/*
 * rv32i core top level
 * one instruction at a time through fetch, decode, execute, memory and
 * write-back, with a single APB4 master for code and data
 */
module riscv_core #(
    parameter int                          ADDR_WIDTH = 20,
    parameter logic [core_pkg::XLEN-1:0]   RESET_PC   = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic [ADDR_WIDTH-1:0]     paddr,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [core_pkg::XLEN-1:0] pwdata,
    output logic [3:0]                pstrb,
    input  logic [core_pkg::XLEN-1:0] prdata,
    input  logic                      pready
);
    import core_pkg::*;

    instr_u                instr;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    alu_op_e               alu_op;
    src_a_e                src_a;
    logic                  use_imm;
    branch_e               branch;
    wb_sel_e               wb_sel;
    logic                  mem_read, mem_write_op;
    mem_size_e             mem_size_op;
    logic [XLEN-1:0]       imm, pc;
    logic [XLEN-1:0]       rs1_data, rs2_data, rd_data;
    logic                  rd_we;
    logic [XLEN-1:0]       alu_a, alu_b, alu_result;
    logic                  alu_eq;

    // transfer request between control and the bus port
    logic                  mem_req, mem_write, mem_done;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [XLEN-1:0]       mem_wdata, mem_rdata;
    mem_size_e             mem_size;

    // operand select
    assign alu_a = (src_a == SRC_PC)   ? pc :
                   (src_a == SRC_ZERO) ? '0 : rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;

    core_control #(.ADDR_WIDTH(ADDR_WIDTH), .RESET_PC(RESET_PC)) u_control (
        .clk(clk), .rst(rst), .instr(instr),
        .branch(branch), .wb_sel(wb_sel), .mem_read(mem_read),
        .mem_write_op(mem_write_op), .mem_size_op(mem_size_op), .imm(imm),
        .rs2_data(rs2_data), .alu_result(alu_result), .alu_eq(alu_eq),
        .pc(pc), .rd_we(rd_we), .rd_data(rd_data),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_size(mem_size),
        .mem_done(mem_done), .mem_rdata(mem_rdata)
    );

    decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
        .alu_op(alu_op), .src_a(src_a), .use_imm(use_imm),
        .branch(branch), .wb_sel(wb_sel), .mem_read(mem_read),
        .mem_write_op(mem_write_op), .mem_size_op(mem_size_op), .imm(imm)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(rd_we), .wdata(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .eq(alu_eq)
    );

    apb_mem_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_apb_port (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_size(mem_size),
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
    );

endmodule
